//--- mmio_soc_settings.svh
`ifndef MMIO_SOC_SETTINGS_SVH
`define MMIO_SOC_SETTINGS_SVH

// scratch RAM window, word organised
`define RAM_BASE 64'h0000_0000_8000_0000
// depth in 32-bit words
`define RAM_WORDS 256

// interrupt controller window
`define PLIC_BASE 64'h0000_0000_0C00_0000

// priority registers sit at base + 4 * id
// global pending bitmap
`define PLIC_PENDING_OFS 64'h0000_1000
// enable bitmap of context 0
`define PLIC_ENABLE_OFS 64'h0000_2000
// context 1 enable is one step further
`define PLIC_CTX1_ENABLE_STEP 64'h0000_0080
// threshold of context 0
`define PLIC_THRESHOLD_OFS 64'h0020_0000
// context 1 threshold and claim one step further
`define PLIC_CTX1_THRESHOLD_STEP 64'h0000_1000
// claim register, read returns winning id
`define PLIC_CLAIM_OFS 64'h0020_0004

// interrupt sources, id 0 means no interrupt
`define IRQ_SOURCES 5
// width of a source priority
`define PRIO_BITS 3

`endif

//--- mmio_soc_pkg.sv
`include "mmio_soc_settings.svh"

package mmio_soc_pkg;

    // bus address and data, full 64 bits
    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_word_t;

    // load/store kind as driven by the core
    // stores use the signed codes
    typedef enum logic [2:0] {
        LS_BYTE   = 3'b000,
        LS_HALF   = 3'b001,
        LS_WORD   = 3'b010,
        LS_DOUBLE = 3'b011,
        LS_BYTE_U = 3'b100,
        LS_HALF_U = 3'b101,
        LS_WORD_U = 3'b110
    } ls_kind_e;

    // decoded bus target
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_PLIC
    } target_e;

    // controller register selected by the address
    typedef enum logic [2:0] {
        PREG_PRIORITY,
        PREG_PENDING,
        PREG_ENABLE0,
        PREG_ENABLE1,
        PREG_THRESHOLD0,
        PREG_THRESHOLD1,
        PREG_CLAIM0,
        PREG_CLAIM1
    } plic_reg_e;

    // one bit per source, bit 0 unused
    typedef logic [`IRQ_SOURCES:0] irq_vec_t;

    // source id, 0 to IRQ_SOURCES
    typedef logic [$clog2(`IRQ_SOURCES + 1)-1:0] src_id_t;

endpackage

//--- bus_request_stage.sv
`timescale 1ns/100ps
`include "mmio_soc_settings.svh"

module bus_request_stage import mmio_soc_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  bus_addr_t bus_address,
    input  bus_word_t bus_write_data,
    input  ls_kind_e  bus_ls_type,
    input  logic      bus_read_enable,
    input  logic      bus_write_enable,
    input  logic      bus_read_done,
    input  logic      bus_write_done,
    output logic      req_valid,
    output logic      req_write,
    output bus_addr_t req_addr,
    output bus_word_t req_wdata,
    output ls_kind_e  req_kind,
    output target_e   req_target,
    output plic_reg_e req_plic_reg,
    output src_id_t   req_source
);

    localparam bus_addr_t RAM_END  = `RAM_BASE + 4 * `RAM_WORDS;
    localparam bus_addr_t PRIO_END = 4 * (`IRQ_SOURCES + 1);

    logic      strobe;
    logic      done_all;
    logic      busy;
    logic      ram_hit;
    logic      plic_hit;
    bus_addr_t plic_off;
    plic_reg_e dec_reg;
    target_e   dec_target;

    assign strobe   = bus_read_enable | bus_write_enable;
    assign done_all = bus_read_done & bus_write_done;

    // address map decode
    assign ram_hit  = (bus_address >= `RAM_BASE) && (bus_address < RAM_END);
    // below the base this wraps to a huge offset, so no hit
    assign plic_off = bus_address - `PLIC_BASE;

    always_comb begin
        plic_hit = 1'b1;
        case (plic_off)
            `PLIC_PENDING_OFS:
                dec_reg = PREG_PENDING;
            `PLIC_ENABLE_OFS:
                dec_reg = PREG_ENABLE0;
            `PLIC_ENABLE_OFS + `PLIC_CTX1_ENABLE_STEP:
                dec_reg = PREG_ENABLE1;
            `PLIC_THRESHOLD_OFS:
                dec_reg = PREG_THRESHOLD0;
            `PLIC_THRESHOLD_OFS + `PLIC_CTX1_THRESHOLD_STEP:
                dec_reg = PREG_THRESHOLD1;
            `PLIC_CLAIM_OFS:
                dec_reg = PREG_CLAIM0;
            `PLIC_CLAIM_OFS + `PLIC_CTX1_THRESHOLD_STEP:
                dec_reg = PREG_CLAIM1;
            default: begin
                // priority words for ids 1..IRQ_SOURCES
                dec_reg  = PREG_PRIORITY;
                plic_hit = (plic_off >= 4) && (plic_off < PRIO_END) &&
                           (plic_off[1:0] == 2'b00);
            end
        endcase
    end

    assign dec_target = ram_hit ? TGT_RAM : (plic_hit ? TGT_PLIC : TGT_NONE);

    // one-cycle request pulse, busy until done comes back
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            req_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            req_valid <= strobe;
            if (strobe) begin
                busy <= 1'b1;
            end else if (!req_valid && done_all) begin
                busy <= 1'b0;
            end
        end
    end

    // request fields, held until the next strobe
    always_ff @(posedge CLOCK_50) begin
        if (strobe) begin
            req_write    <= bus_write_enable;
            req_addr     <= bus_address;
            req_wdata    <= bus_write_data;
            req_kind     <= bus_ls_type;
            req_target   <= dec_target;
            req_plic_reg <= dec_reg;
            req_source   <= plic_off[2 +: $bits(src_id_t)];
        end
    end

    // master waits for done before the next access
    a_no_strobe_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        strobe |-> !req_valid && !(busy && !done_all));

    a_one_strobe: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

endmodule

//--- scratch_ram.sv
`timescale 1ns/100ps
`include "mmio_soc_settings.svh"

module scratch_ram import mmio_soc_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      req_valid,
    input  logic      req_write,
    input  bus_addr_t req_addr,
    input  bus_word_t req_wdata,
    input  ls_kind_e  req_kind,
    input  target_e   req_target,
    output bus_word_t ram_rdata,
    output logic      ram_ack
);

    localparam int AW = $clog2(`RAM_WORDS);

    typedef enum logic {
        BEAT_FIRST,
        BEAT_SECOND
    } beat_e;

    logic [31:0] mem [`RAM_WORDS];

    beat_e       beat;
    logic        sel;
    bus_addr_t   ram_off;
    logic [AW-1:0] word_idx;
    logic [AW-1:0] word_hi;
    logic [4:0]  shamt;
    logic [31:0] cur_word;
    logic [31:0] shifted;
    logic [31:0] wr_mask;
    logic [31:0] merged;
    bus_word_t   load_val;

    assign sel      = req_valid && (req_target == TGT_RAM);
    assign ram_off  = req_addr - `RAM_BASE;
    assign word_idx = ram_off[AW+1:2];
    // high word of a doubleword
    assign word_hi  = word_idx + 1'b1;
    // byte offset in bits
    assign shamt    = {req_addr[1:0], 3'b000};

    assign cur_word = mem[word_idx];
    assign shifted  = cur_word >> shamt;

    // little endian, byte 0 in bits 7:0
    always_comb begin
        case (req_kind)
            LS_BYTE:   load_val = {{56{shifted[7]}}, shifted[7:0]};
            LS_HALF:   load_val = {{48{shifted[15]}}, shifted[15:0]};
            LS_WORD:   load_val = {{32{shifted[31]}}, shifted};
            LS_BYTE_U: load_val = {56'd0, shifted[7:0]};
            LS_HALF_U: load_val = {48'd0, shifted[15:0]};
            // low word now, high word on the second beat
            default:   load_val = {32'd0, cur_word};
        endcase
    end

    // byte lanes touched by a store
    always_comb begin
        case (req_kind)
            LS_BYTE, LS_BYTE_U: wr_mask = 32'h0000_00ff << shamt;
            LS_HALF, LS_HALF_U: wr_mask = 32'h0000_ffff << shamt;
            default:            wr_mask = 32'hffff_ffff;
        endcase
    end

    assign merged = (cur_word & ~wr_mask) | ((req_wdata[31:0] << shamt) & wr_mask);

    // beat sequencing and ack
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat    <= BEAT_FIRST;
            ram_ack <= 1'b0;
        end else begin
            ram_ack <= 1'b0;
            if (beat == BEAT_SECOND) begin
                beat    <= BEAT_FIRST;
                ram_ack <= 1'b1;
            end else if (sel) begin
                if (req_kind == LS_DOUBLE) begin
                    beat <= BEAT_SECOND;
                end else begin
                    ram_ack <= 1'b1;
                end
            end
        end
    end

    // storage and read data
    always_ff @(posedge CLOCK_50) begin
        if (beat == BEAT_SECOND) begin
            // request fields still held by the request stage
            if (req_write) begin
                mem[word_hi] <= req_wdata[63:32];
            end else begin
                ram_rdata[63:32] <= mem[word_hi];
            end
        end else if (sel) begin
            if (req_write) begin
                mem[word_idx] <= merged;
            end else begin
                ram_rdata <= load_val;
            end
        end
    end

    a_half_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sel && (req_kind inside {LS_HALF, LS_HALF_U}) |-> !req_addr[0]);

endmodule

//--- plic_core.sv
`timescale 1ns/100ps
`include "mmio_soc_settings.svh"

module plic_core import mmio_soc_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      req_valid,
    input  logic      req_write,
    input  bus_word_t req_wdata,
    input  target_e   req_target,
    input  plic_reg_e req_plic_reg,
    input  src_id_t   req_source,
    input  irq_vec_t  irq_sources,
    output bus_word_t plic_rdata,
    output logic      plic_ack,
    output logic      meip_interrupt,
    output logic      msip_interrupt
);

    logic [`PRIO_BITS-1:0] prio [1:`IRQ_SOURCES];
    logic [`PRIO_BITS-1:0] threshold [2];
    irq_vec_t enable [2];
    irq_vec_t pending;
    irq_vec_t clr_mask;
    src_id_t  claim_id [2];
    logic     sel;
    logic     claim_rd;

    assign sel      = req_valid && (req_target == TGT_PLIC);
    assign claim_rd = sel && !req_write && (req_plic_reg inside {PREG_CLAIM0, PREG_CLAIM1});

    // per context: highest priority above threshold
    // strict compare keeps the lowest id on ties
    always_comb begin
        logic [`PRIO_BITS-1:0] best;
        for (int ctx = 0; ctx < 2; ctx++) begin
            claim_id[ctx] = '0;
            best = threshold[ctx];
            for (int s = 1; s <= `IRQ_SOURCES; s++) begin
                if (pending[s] && enable[ctx][s] && (prio[s] > best)) begin
                    best = prio[s];
                    claim_id[ctx] = src_id_t'(s);
                end
            end
        end
    end

    assign meip_interrupt = (claim_id[0] != '0);
    assign msip_interrupt = (claim_id[1] != '0);

    // claim read clears the bit it returns
    always_comb begin
        clr_mask = '0;
        if (sel && !req_write && (req_plic_reg == PREG_CLAIM0)) begin
            clr_mask[claim_id[0]] = 1'b1;
        end
        if (sel && !req_write && (req_plic_reg == PREG_CLAIM1)) begin
            clr_mask[claim_id[1]] = 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending   <= '0;
            enable[0] <= '0;
            enable[1] <= '0;
            threshold[0] <= '0;
            threshold[1] <= '0;
            for (int s = 1; s <= `IRQ_SOURCES; s++) begin
                prio[s] <= '0;
            end
            plic_ack <= 1'b0;
        end else begin
            // level sampled every cycle, clear wins
            pending  <= (pending | {irq_sources[`IRQ_SOURCES:1], 1'b0}) & ~clr_mask;
            plic_ack <= sel;
            if (sel && req_write) begin
                case (req_plic_reg)
                    PREG_PRIORITY:   prio[req_source] <= req_wdata[`PRIO_BITS-1:0];
                    PREG_ENABLE0:    enable[0] <= {req_wdata[`IRQ_SOURCES:1], 1'b0};
                    PREG_ENABLE1:    enable[1] <= {req_wdata[`IRQ_SOURCES:1], 1'b0};
                    PREG_THRESHOLD0: threshold[0] <= req_wdata[`PRIO_BITS-1:0];
                    PREG_THRESHOLD1: threshold[1] <= req_wdata[`PRIO_BITS-1:0];
                    // pending and claims are read only
                    default: ;
                endcase
            end
        end
    end

    // read data
    always_ff @(posedge CLOCK_50) begin
        if (sel && !req_write) begin
            case (req_plic_reg)
                PREG_PRIORITY:   plic_rdata <= 64'(prio[req_source]);
                PREG_PENDING:    plic_rdata <= 64'(pending);
                PREG_ENABLE0:    plic_rdata <= 64'(enable[0]);
                PREG_ENABLE1:    plic_rdata <= 64'(enable[1]);
                PREG_THRESHOLD0: plic_rdata <= 64'(threshold[0]);
                PREG_THRESHOLD1: plic_rdata <= 64'(threshold[1]);
                PREG_CLAIM0:     plic_rdata <= 64'(claim_id[0]);
                default:         plic_rdata <= 64'(claim_id[1]);
            endcase
        end
    end

    a_claim_range: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        claim_rd |=> plic_ack && (plic_rdata <= `IRQ_SOURCES));

endmodule

//--- bus_response_stage.sv
`timescale 1ns/100ps

module bus_response_stage import mmio_soc_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      req_valid,
    input  logic      req_write,
    input  target_e   req_target,
    input  bus_word_t ram_rdata,
    input  logic      ram_ack,
    input  bus_word_t plic_rdata,
    input  logic      plic_ack,
    output bus_word_t bus_read_data,
    output logic      bus_read_done,
    output logic      bus_write_done
);

    logic unmapped_q;
    logic finish;

    // unmapped access ends one cycle after the request
    assign finish = ram_ack | plic_ack | unmapped_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            unmapped_q     <= 1'b0;
        end else begin
            unmapped_q <= req_valid && (req_target == TGT_NONE);
            // lower the flag of the access in flight
            if (req_valid) begin
                if (req_write) begin
                    bus_write_done <= 1'b0;
                end else begin
                    bus_read_done <= 1'b0;
                end
            end
            if (finish) begin
                bus_read_done  <= 1'b1;
                bus_write_done <= 1'b1;
            end
        end
    end

    // only reads update the data, unmapped reads give zero
    always_ff @(posedge CLOCK_50) begin
        if (finish && !bus_read_done) begin
            if (ram_ack) begin
                bus_read_data <= ram_rdata;
            end else if (plic_ack) begin
                bus_read_data <= plic_rdata;
            end else begin
                bus_read_data <= '0;
            end
        end
    end

endmodule

//--- mmio_soc_top.sv
`timescale 1ns/100ps

module mmio_soc_top import mmio_soc_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  bus_addr_t bus_address,
    input  bus_word_t bus_write_data,
    input  ls_kind_e  bus_ls_type,
    input  logic      bus_read_enable,
    input  logic      bus_write_enable,
    output bus_word_t bus_read_data,
    output logic      bus_read_done,
    output logic      bus_write_done,
    input  irq_vec_t  irq_sources,
    output logic      meip_interrupt,
    output logic      msip_interrupt
);

    // request fields shared by both targets
    logic      req_valid;
    logic      req_write;
    bus_addr_t req_addr;
    bus_word_t req_wdata;
    ls_kind_e  req_kind;
    target_e   req_target;
    plic_reg_e req_plic_reg;
    src_id_t   req_source;

    // target replies
    bus_word_t ram_rdata;
    logic      ram_ack;
    bus_word_t plic_rdata;
    logic      plic_ack;

    bus_request_stage bus_request_stage_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .req_valid        (req_valid),
        .req_write        (req_write),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .req_kind         (req_kind),
        .req_target       (req_target),
        .req_plic_reg     (req_plic_reg),
        .req_source       (req_source)
    );

    scratch_ram scratch_ram_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_kind   (req_kind),
        .req_target (req_target),
        .ram_rdata  (ram_rdata),
        .ram_ack    (ram_ack)
    );

    plic_core plic_core_inst (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_wdata      (req_wdata),
        .req_target     (req_target),
        .req_plic_reg   (req_plic_reg),
        .req_source     (req_source),
        .irq_sources    (irq_sources),
        .plic_rdata     (plic_rdata),
        .plic_ack       (plic_ack),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

    bus_response_stage bus_response_stage_inst (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_target     (req_target),
        .ram_rdata      (ram_rdata),
        .ram_ack        (ram_ack),
        .plic_rdata     (plic_rdata),
        .plic_ack       (plic_ack),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done)
    );

endmodule

//--- mmio_soc_tb.sv
`timescale 1ns/100ps
`include "mmio_soc_settings.svh"

module mmio_soc_tb import mmio_soc_pkg::*; ();

    // kinds of table entry
    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_IRQ
    } op_e;

    // one row of stimulus and expected results
    typedef struct {
        string     name;
        op_e       op;
        bus_addr_t addr;
        ls_kind_e  kind;
        bus_word_t wdata;
        bus_word_t exp_data;
        // {msip, meip}
        logic [1:0] exp_irq;
    } entry_t;

    localparam bus_addr_t SIZE_ADDR     = `RAM_BASE + 64'h10;
    localparam bus_addr_t MERGE_ADDR    = `RAM_BASE + 64'h20;
    localparam bus_addr_t DOUBLE_ADDR   = `RAM_BASE + 64'h40;
    // low address bits alias onto the merge word if wrongly taken as RAM
    localparam bus_addr_t UNMAPPED_ADDR = 64'h0000_0000_4000_0020;
    localparam bus_addr_t PENDING_ADDR  = `PLIC_BASE + `PLIC_PENDING_OFS;
    localparam bus_addr_t ENABLE0_ADDR  = `PLIC_BASE + `PLIC_ENABLE_OFS;
    localparam bus_addr_t ENABLE1_ADDR  = ENABLE0_ADDR + `PLIC_CTX1_ENABLE_STEP;
    localparam bus_addr_t THRESH0_ADDR  = `PLIC_BASE + `PLIC_THRESHOLD_OFS;
    localparam bus_addr_t THRESH1_ADDR  = THRESH0_ADDR + `PLIC_CTX1_THRESHOLD_STEP;
    localparam bus_addr_t CLAIM0_ADDR   = `PLIC_BASE + `PLIC_CLAIM_OFS;
    localparam bus_addr_t CLAIM1_ADDR   = CLAIM0_ADDR + `PLIC_CTX1_THRESHOLD_STEP;

    logic      CLOCK_50;
    logic      KEY0;
    bus_addr_t bus_address;
    bus_word_t bus_write_data;
    ls_kind_e  bus_ls_type;
    logic      bus_read_enable;
    logic      bus_write_enable;
    bus_word_t bus_read_data;
    logic      bus_read_done;
    logic      bus_write_done;
    irq_vec_t  irq_sources;
    logic      meip_interrupt;
    logic      msip_interrupt;

    entry_t     tests[$];
    // byte image of the RAM, offset from RAM_BASE
    logic [7:0] ref_bytes [4 * `RAM_WORDS];
    // source priorities for the controller tests
    int         prio_cfg [1:`IRQ_SOURCES] = '{2, 5, 5, 1, 3};
    integer     seed;
    int         cycles;
    int         cycle_limit;

    mmio_soc_top mmio_soc_top_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .irq_sources      (irq_sources),
        .meip_interrupt   (meip_interrupt),
        .msip_interrupt   (msip_interrupt)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // run limit, 12 cycles per entry plus reset
    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $fatal(1, "stopped on timeout");
        end
    end

    task automatic check_data(input string name, input bus_word_t exp, input bus_word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_irq(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected irq %b, actual irq %b", name, exp, act);
            $display("Verification failed");
            $fatal(1, "interrupt mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("Verification failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // bytes moved by one access
    function automatic int access_bytes(input ls_kind_e kind);
        case (kind)
            LS_BYTE, LS_BYTE_U: return 1;
            LS_HALF, LS_HALF_U: return 2;
            LS_DOUBLE:          return 8;
            default:            return 4;
        endcase
    endfunction

    // gather bytes little endian, then extend by kind
    function automatic bus_word_t expect_load(input bus_addr_t addr, input ls_kind_e kind);
        int        base;
        int        n;
        int        i;
        bus_word_t raw;
        base = int'(addr - `RAM_BASE);
        n    = access_bytes(kind);
        raw  = '0;
        for (i = 0; i < n; i++) begin
            raw[8*i +: 8] = ref_bytes[base + i];
        end
        // signed kinds copy the top loaded bit upward
        if ((kind inside {LS_BYTE, LS_HALF, LS_WORD}) && raw[8*n-1]) begin
            for (i = 8 * n; i < 64; i++) begin
                raw[i] = 1'b1;
            end
        end
        return raw;
    endfunction

    task automatic add_entry(input string name, input op_e op, input bus_addr_t addr,
                             input ls_kind_e kind, input bus_word_t wdata,
                             input bus_word_t exp_data, input logic [1:0] exp_irq);
        entry_t e;
        e.name     = name;
        e.op       = op;
        e.addr     = addr;
        e.kind     = kind;
        e.wdata    = wdata;
        e.exp_data = exp_data;
        e.exp_irq  = exp_irq;
        tests.push_back(e);
    endtask

    // store into the byte image and queue the write
    task automatic ram_write(input string name, input bus_addr_t addr, input ls_kind_e kind,
                             input bus_word_t data);
        int base;
        int n;
        int i;
        base = int'(addr - `RAM_BASE);
        n    = access_bytes(kind);
        for (i = 0; i < n; i++) begin
            ref_bytes[base + i] = data[8*i +: 8];
        end
        add_entry(name, OP_WRITE, addr, kind, data, '0, 2'b00);
    endtask

    task automatic ram_read(input string name, input bus_addr_t addr, input ls_kind_e kind);
        add_entry(name, OP_READ, addr, kind, '0, expect_load(addr, kind), 2'b00);
    endtask

    task automatic build_table();
        int          round;
        int          off;
        int          s;
        logic [31:0] word;
        // every load kind at every legal offset, second round forces sign bits
        for (round = 0; round < 2; round++) begin
            word = $random(seed);
            if (round == 1) begin
                word = word | 32'h8080_8080;
            end
            ram_write($sformatf("sw size r%0d", round), SIZE_ADDR, LS_WORD, {32'd0, word});
            ram_read($sformatf("lw r%0d", round), SIZE_ADDR, LS_WORD);
            ram_read($sformatf("lwu r%0d", round), SIZE_ADDR, LS_WORD_U);
            for (off = 0; off < 4; off += 2) begin
                ram_read($sformatf("lh off%0d r%0d", off, round), SIZE_ADDR + off, LS_HALF);
                ram_read($sformatf("lhu off%0d r%0d", off, round), SIZE_ADDR + off, LS_HALF_U);
            end
            for (off = 0; off < 4; off++) begin
                ram_read($sformatf("lb off%0d r%0d", off, round), SIZE_ADDR + off, LS_BYTE);
                ram_read($sformatf("lbu off%0d r%0d", off, round), SIZE_ADDR + off, LS_BYTE_U);
            end
        end
        // byte and half merges into a known word
        ram_write("sw merge base", MERGE_ADDR, LS_WORD, 64'h1122_3344);
        ram_write("sb merge off1", MERGE_ADDR + 1, LS_BYTE, 64'hAA);
        ram_read("lw after sb", MERGE_ADDR, LS_WORD);
        ram_write("sh merge off2", MERGE_ADDR + 2, LS_HALF, 64'($random(seed)));
        ram_read("lw after sh", MERGE_ADDR, LS_WORD);
        ram_write("sb merge off0", MERGE_ADDR, LS_BYTE, 64'($random(seed)));
        ram_read("lw after sb0", MERGE_ADDR, LS_WORD);
        // doubleword across two words
        ram_write("sd", DOUBLE_ADDR, LS_DOUBLE, {32'($random(seed)), 32'($random(seed))});
        ram_read("ld", DOUBLE_ADDR, LS_DOUBLE);
        ram_read("lw upper half", DOUBLE_ADDR + 4, LS_WORD);
        ram_read("lwu lower half", DOUBLE_ADDR, LS_WORD_U);
        // unmapped access reads zero, write lands nowhere
        add_entry("unmapped read", OP_READ, UNMAPPED_ADDR, LS_WORD, '0, '0, 2'b00);
        add_entry("unmapped write", OP_WRITE, UNMAPPED_ADDR, LS_WORD, 64'hDEAD_BEEF, '0, 2'b00);
        ram_read("lw after unmapped write", MERGE_ADDR, LS_WORD);
        add_entry("unmapped read again", OP_READ, UNMAPPED_ADDR, LS_DOUBLE, '0, '0, 2'b00);
        // controller setup, ctx0 sees 1 2 3 5, ctx1 sees 4 5
        for (s = 1; s <= `IRQ_SOURCES; s++) begin
            add_entry($sformatf("prio %0d", s), OP_WRITE, `PLIC_BASE + bus_addr_t'(4 * s),
                      LS_WORD, bus_word_t'(prio_cfg[s]), '0, 2'b00);
        end
        add_entry("enable0", OP_WRITE, ENABLE0_ADDR, LS_WORD, 64'h2E, '0, 2'b00);
        add_entry("enable1", OP_WRITE, ENABLE1_ADDR, LS_WORD, 64'h30, '0, 2'b00);
        add_entry("threshold0 1", OP_WRITE, THRESH0_ADDR, LS_WORD, 64'd1, '0, 2'b00);
        add_entry("threshold1 2", OP_WRITE, THRESH1_ADDR, LS_WORD, 64'd2, '0, 2'b00);
        // source 4 at priority 1 stays below ctx1 threshold
        add_entry("pulse 4", OP_IRQ, '0, LS_WORD, 64'h10, '0, 2'b00);
        add_entry("pending 4", OP_READ, PENDING_ADDR, LS_WORD, '0, 64'h10, 2'b00);
        add_entry("pulse 1 5", OP_IRQ, '0, LS_WORD, 64'h22, '0, 2'b11);
        add_entry("pulse 2 3", OP_IRQ, '0, LS_WORD, 64'h0C, '0, 2'b11);
        // 2 and 3 tie at priority 5, lower id first
        add_entry("claim0 first", OP_READ, CLAIM0_ADDR, LS_WORD, '0, 64'd2, 2'b11);
        add_entry("claim0 second", OP_READ, CLAIM0_ADDR, LS_WORD, '0, 64'd3, 2'b11);
        add_entry("claim1 first", OP_READ, CLAIM1_ADDR, LS_WORD, '0, 64'd5, 2'b01);
        add_entry("claim1 empty", OP_READ, CLAIM1_ADDR, LS_WORD, '0, 64'd0, 2'b01);
        add_entry("threshold0 2", OP_WRITE, THRESH0_ADDR, LS_WORD, 64'd2, '0, 2'b00);
        add_entry("threshold1 0", OP_WRITE, THRESH1_ADDR, LS_WORD, 64'd0, '0, 2'b10);
        add_entry("claim1 low prio", OP_READ, CLAIM1_ADDR, LS_WORD, '0, 64'd4, 2'b00);
        add_entry("threshold0 back", OP_WRITE, THRESH0_ADDR, LS_WORD, 64'd1, '0, 2'b01);
        add_entry("claim0 third", OP_READ, CLAIM0_ADDR, LS_WORD, '0, 64'd1, 2'b00);
        add_entry("claim0 empty", OP_READ, CLAIM0_ADDR, LS_WORD, '0, 64'd0, 2'b00);
        add_entry("pending clear", OP_READ, PENDING_ADDR, LS_WORD, '0, 64'd0, 2'b00);
        add_entry("prio 2 readback", OP_READ, `PLIC_BASE + 64'd8, LS_WORD, '0, 64'd5, 2'b00);
    endtask

    // done falls first, then rises at completion
    task automatic wait_done(input logic is_write);
        @(negedge CLOCK_50);
        while ((is_write ? bus_write_done : bus_read_done) == 1'b1) begin
            @(negedge CLOCK_50);
        end
        while ((is_write ? bus_write_done : bus_read_done) == 1'b0) begin
            @(negedge CLOCK_50);
        end
    endtask

    task automatic apply_entry(input entry_t e);
        @(posedge CLOCK_50);
        if (e.op == OP_IRQ) begin
            // one-cycle pulse on the sources
            irq_sources <= irq_vec_t'(e.wdata);
            @(posedge CLOCK_50);
            irq_sources <= '0;
            @(negedge CLOCK_50);
        end else begin
            bus_address      <= e.addr;
            bus_write_data   <= e.wdata;
            bus_ls_type      <= e.kind;
            bus_write_enable <= (e.op == OP_WRITE);
            bus_read_enable  <= (e.op == OP_READ);
            @(posedge CLOCK_50);
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
            wait_done(e.op == OP_WRITE);
            if (e.op == OP_READ) begin
                check_data(e.name, e.exp_data, bus_read_data);
            end
        end
        check_irq(e.name, e.exp_irq, {msip_interrupt, meip_interrupt});
    endtask

    initial begin
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = LS_WORD;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        irq_sources      = '0;
        cycles           = 0;
        seed             = 32'h6abcb3f6;
        build_table();
        cycle_limit = 16 + 8 + 12 * tests.size();
        repeat (16) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        // idle state straight after reset
        @(negedge CLOCK_50);
        check_flag("reset read done", 1'b1, bus_read_done);
        check_flag("reset write done", 1'b1, bus_write_done);
        check_irq("reset irq", 2'b00, {msip_interrupt, meip_interrupt});
        foreach (tests[t]) begin
            apply_entry(tests[t]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

//--- mmio_soc.f
+incdir+.
mmio_soc_pkg.sv
bus_request_stage.sv
scratch_ram.sv
plic_core.sv
bus_response_stage.sv
mmio_soc_top.sv
mmio_soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mmio_soc.f --top-module mmio_soc_tb

./obj_dir/Vmmio_soc_tb | tee sim.log

# the log decides the result
grep -qx "Verification passed" sim.log
